// ==== common/exec_pkg.sv ====
package exec_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // field widths and types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int WORD_W     = 32;
    localparam int EXE_FUN_W  = 5;
    localparam int MEM_WEN_W  = 4;
    localparam int WB_SEL_W   = 4;
    localparam int REG_ADDR_W = 5;
    localparam int CSR_CMD_W  = 3;

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [EXE_FUN_W-1:0]  exe_fun_t;
    typedef logic [MEM_WEN_W-1:0]  mem_wen_t;
    typedef logic [WB_SEL_W-1:0]   wb_sel_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [CSR_CMD_W-1:0]  csr_cmd_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // execute function codes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // ALU_X is what a bubble carries, so it must stay zero-result
    localparam exe_fun_t ALU_X      = 5'd0;
    localparam exe_fun_t ALU_ADD    = 5'd1;
    localparam exe_fun_t ALU_SUB    = 5'd2;
    localparam exe_fun_t ALU_AND    = 5'd3;
    localparam exe_fun_t ALU_OR     = 5'd4;
    localparam exe_fun_t ALU_XOR    = 5'd5;
    localparam exe_fun_t ALU_SLL    = 5'd6;
    localparam exe_fun_t ALU_SRL    = 5'd7;
    localparam exe_fun_t ALU_SRA    = 5'd8;
    localparam exe_fun_t ALU_SLT    = 5'd9;
    localparam exe_fun_t ALU_SLTU   = 5'd10;
    localparam exe_fun_t BR_BEQ     = 5'd11;
    localparam exe_fun_t BR_BNE     = 5'd12;
    localparam exe_fun_t BR_BLT     = 5'd13;
    localparam exe_fun_t BR_BGE     = 5'd14;
    localparam exe_fun_t BR_BLTU    = 5'd15;
    localparam exe_fun_t BR_BGEU    = 5'd16;
    localparam exe_fun_t ALU_JALR   = 5'd17;
    localparam exe_fun_t ALU_COPY1  = 5'd18;
    localparam exe_fun_t ALU_MUL    = 5'd19;
    localparam exe_fun_t ALU_MULH   = 5'd20;
    localparam exe_fun_t ALU_MULHSU = 5'd21;
    localparam exe_fun_t ALU_MULHU  = 5'd22;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bubble values
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam word_t    REGPC_NOP   = 32'h0000_0000;
    localparam mem_wen_t MEN_X       = 4'd0;
    localparam logic     REN_X       = 1'b0;
    localparam wb_sel_t  WB_X        = 4'd0;
    localparam csr_cmd_t CSR_X       = 3'd0;
    localparam word_t    WORD_POISON = 32'hffff_ffff;

endpackage

// ==== execute/alu.sv ====
module alu #(
    parameter bit has_mul = 1'b1
) (
    input  exec_pkg::exe_fun_t fun,
    input  exec_pkg::word_t    op1,
    input  exec_pkg::word_t    op2,
    output exec_pkg::word_t    result
);

    import exec_pkg::*;

    logic [63:0] prod_ss;
    logic [63:0] prod_su;
    logic [63:0] prod_uu;
    word_t       mul_result;
    logic [4:0]  shamt;

    assign shamt = op2[4:0];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // RV32M multiply group
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // operands are widened to 64 bits first, so each product is exact mod 2^64
    assign prod_ss = 64'($signed(op1)) * 64'($signed(op2));
    assign prod_su = 64'($signed(op1)) * 64'(op2);
    assign prod_uu = 64'(op1) * 64'(op2);

    always_comb begin
        mul_result = '0;
        if (has_mul) begin
            case (fun)
                ALU_MUL:    mul_result = prod_ss[31:0];
                ALU_MULH:   mul_result = prod_ss[63:32];
                ALU_MULHSU: mul_result = prod_su[63:32];
                ALU_MULHU:  mul_result = prod_uu[63:32];
                default:    mul_result = '0;
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // base RV32I functions
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        case (fun)
            ALU_ADD:   result = op1 + op2;
            ALU_SUB:   result = op1 - op2;
            ALU_AND:   result = op1 & op2;
            ALU_OR:    result = op1 | op2;
            ALU_XOR:   result = op1 ^ op2;
            ALU_SLL:   result = op1 << shamt;
            ALU_SRL:   result = op1 >> shamt;
            ALU_SRA:   result = word_t'($signed(op1) >>> shamt);
            ALU_SLT:   result = word_t'($signed(op1) < $signed(op2));
            ALU_SLTU:  result = word_t'(op1 < op2);
            // jump target is always halfword aligned
            ALU_JALR:  result = (op1 + op2) & ~32'd1;
            ALU_COPY1: result = op1;
            ALU_MUL,
            ALU_MULH,
            ALU_MULHSU,
            ALU_MULHU: result = mul_result;
            // branch codes and ALU_X land here
            default:   result = '0;
        endcase
    end

endmodule

// ==== execute/branch_unit.sv ====
module branch_unit (
    input  exec_pkg::exe_fun_t fun,
    input  exec_pkg::word_t    op1,
    input  exec_pkg::word_t    op2,
    input  exec_pkg::word_t    pc,
    input  exec_pkg::word_t    imm_b,
    output logic               take,
    output exec_pkg::word_t    target
);

    import exec_pkg::*;

    logic eq;
    logic lt_s;
    logic lt_u;

    assign eq   = (op1 == op2);
    assign lt_s = ($signed(op1) < $signed(op2));
    assign lt_u = (op1 < op2);

    always_comb begin
        case (fun)
            BR_BEQ:  take = eq;
            BR_BNE:  take = !eq;
            BR_BLT:  take = lt_s;
            BR_BGE:  take = !lt_s;
            BR_BLTU: take = lt_u;
            BR_BGEU: take = !lt_u;
            default: take = 1'b0;
        endcase
    end

    // computed for every code, only meaningful when take is set
    assign target = pc + imm_b;

endmodule

// ==== execute/operand_hold.sv ====
module operand_hold (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                stall_flg,
    input  logic                flush,
    input  exec_pkg::word_t     in_reg_pc,
    input  exec_pkg::exe_fun_t  in_exe_fun,
    input  exec_pkg::word_t     in_op1_data,
    input  exec_pkg::word_t     in_op2_data,
    input  exec_pkg::word_t     in_rs2_data,
    input  exec_pkg::mem_wen_t  in_mem_wen,
    input  logic                in_rf_wen,
    input  exec_pkg::wb_sel_t   in_wb_sel,
    input  exec_pkg::reg_addr_t in_wb_addr,
    input  exec_pkg::csr_cmd_t  in_csr_cmd,
    input  logic                in_jmp_flg,
    input  exec_pkg::word_t     in_imm_i,
    input  exec_pkg::word_t     in_imm_b,
    output exec_pkg::word_t     cur_reg_pc,
    output exec_pkg::exe_fun_t  cur_exe_fun,
    output exec_pkg::word_t     cur_op1_data,
    output exec_pkg::word_t     cur_op2_data,
    output exec_pkg::word_t     cur_rs2_data,
    output exec_pkg::mem_wen_t  cur_mem_wen,
    output logic                cur_rf_wen,
    output exec_pkg::wb_sel_t   cur_wb_sel,
    output exec_pkg::reg_addr_t cur_wb_addr,
    output exec_pkg::csr_cmd_t  cur_csr_cmd,
    output logic                cur_jmp_flg,
    output exec_pkg::word_t     cur_imm_i,
    output exec_pkg::word_t     cur_imm_b
);

    import exec_pkg::*;

    word_t     save_reg_pc;
    exe_fun_t  save_exe_fun;
    word_t     save_op1_data;
    word_t     save_op2_data;
    word_t     save_rs2_data;
    mem_wen_t  save_mem_wen;
    logic      save_rf_wen;
    wb_sel_t   save_wb_sel;
    reg_addr_t save_wb_addr;
    csr_cmd_t  save_csr_cmd;
    logic      save_jmp_flg;
    word_t     save_imm_i;
    word_t     save_imm_b;

    // under stall the saved copy replays, otherwise the live inputs pass
    assign cur_reg_pc   = stall_flg ? save_reg_pc   : in_reg_pc;
    assign cur_exe_fun  = stall_flg ? save_exe_fun  : in_exe_fun;
    assign cur_op1_data = stall_flg ? save_op1_data : in_op1_data;
    assign cur_op2_data = stall_flg ? save_op2_data : in_op2_data;
    assign cur_rs2_data = stall_flg ? save_rs2_data : in_rs2_data;
    assign cur_mem_wen  = stall_flg ? save_mem_wen  : in_mem_wen;
    assign cur_rf_wen   = stall_flg ? save_rf_wen   : in_rf_wen;
    assign cur_wb_sel   = stall_flg ? save_wb_sel   : in_wb_sel;
    assign cur_wb_addr  = stall_flg ? save_wb_addr  : in_wb_addr;
    assign cur_csr_cmd  = stall_flg ? save_csr_cmd  : in_csr_cmd;
    assign cur_jmp_flg  = stall_flg ? save_jmp_flg  : in_jmp_flg;
    assign cur_imm_i    = stall_flg ? save_imm_i    : in_imm_i;
    assign cur_imm_b    = stall_flg ? save_imm_b    : in_imm_b;

    // the held bubble keeps poison in pc and imm_b, so a replayed bubble
    // shows their sum as its branch target
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n || flush) begin
            save_reg_pc   <= WORD_POISON;
            save_exe_fun  <= ALU_X;
            save_op1_data <= WORD_POISON;
            save_op2_data <= WORD_POISON;
            save_rs2_data <= WORD_POISON;
            save_mem_wen  <= MEN_X;
            save_rf_wen   <= REN_X;
            save_wb_sel   <= WB_X;
            save_wb_addr  <= '0;
            save_csr_cmd  <= CSR_X;
            save_jmp_flg  <= 1'b0;
            save_imm_i    <= WORD_POISON;
            save_imm_b    <= WORD_POISON;
        end else begin
            save_reg_pc   <= cur_reg_pc;
            save_exe_fun  <= cur_exe_fun;
            save_op1_data <= cur_op1_data;
            save_op2_data <= cur_op2_data;
            save_rs2_data <= cur_rs2_data;
            save_mem_wen  <= cur_mem_wen;
            save_rf_wen   <= cur_rf_wen;
            save_wb_sel   <= cur_wb_sel;
            save_wb_addr  <= cur_wb_addr;
            save_csr_cmd  <= cur_csr_cmd;
            save_jmp_flg  <= cur_jmp_flg;
            save_imm_i    <= cur_imm_i;
            save_imm_b    <= cur_imm_b;
        end
    end

    // a stall right after a flush must replay the bubble, not the flushed op
    a_stall_after_flush: assert property (
        @(posedge clk) disable iff (!arst_n)
        flush |=> (stall_flg -> (cur_exe_fun == ALU_X))
    );

endmodule

// ==== execute/execute_stage.sv ====
module execute_stage #(
    parameter bit has_mul = 1'b1
) (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                stall_flg,
    input  logic                wb_branch_hazard,
    input  exec_pkg::word_t     in_reg_pc,
    input  exec_pkg::exe_fun_t  in_exe_fun,
    input  exec_pkg::word_t     in_op1_data,
    input  exec_pkg::word_t     in_op2_data,
    input  exec_pkg::word_t     in_rs2_data,
    input  exec_pkg::mem_wen_t  in_mem_wen,
    input  logic                in_rf_wen,
    input  exec_pkg::wb_sel_t   in_wb_sel,
    input  exec_pkg::reg_addr_t in_wb_addr,
    input  exec_pkg::csr_cmd_t  in_csr_cmd,
    input  logic                in_jmp_flg,
    input  exec_pkg::word_t     in_imm_i,
    input  exec_pkg::word_t     in_imm_b,
    output exec_pkg::word_t     alu_out,
    output logic                br_flg,
    output exec_pkg::word_t     br_target,
    output exec_pkg::word_t     out_reg_pc,
    output exec_pkg::mem_wen_t  out_mem_wen,
    output logic                out_rf_wen,
    output exec_pkg::word_t     out_rs2_data,
    output exec_pkg::word_t     out_op1_data,
    output exec_pkg::wb_sel_t   out_wb_sel,
    output exec_pkg::reg_addr_t out_wb_addr,
    output exec_pkg::csr_cmd_t  out_csr_cmd,
    output logic                out_jmp_flg,
    output exec_pkg::word_t     out_imm_i
);

    import exec_pkg::*;

    word_t     cur_reg_pc;
    exe_fun_t  cur_exe_fun;
    word_t     cur_op1_data;
    word_t     cur_op2_data;
    word_t     cur_rs2_data;
    mem_wen_t  cur_mem_wen;
    logic      cur_rf_wen;
    wb_sel_t   cur_wb_sel;
    reg_addr_t cur_wb_addr;
    csr_cmd_t  cur_csr_cmd;
    logic      cur_jmp_flg;
    word_t     cur_imm_i;
    word_t     cur_imm_b;
    word_t     alu_result;
    logic      br_take;
    word_t     br_addr;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // operand selection and compute
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    operand_hold u_hold (
        .clk          (clk),
        .arst_n       (arst_n),
        .stall_flg    (stall_flg),
        .flush        (wb_branch_hazard),
        .in_reg_pc    (in_reg_pc),
        .in_exe_fun   (in_exe_fun),
        .in_op1_data  (in_op1_data),
        .in_op2_data  (in_op2_data),
        .in_rs2_data  (in_rs2_data),
        .in_mem_wen   (in_mem_wen),
        .in_rf_wen    (in_rf_wen),
        .in_wb_sel    (in_wb_sel),
        .in_wb_addr   (in_wb_addr),
        .in_csr_cmd   (in_csr_cmd),
        .in_jmp_flg   (in_jmp_flg),
        .in_imm_i     (in_imm_i),
        .in_imm_b     (in_imm_b),
        .cur_reg_pc   (cur_reg_pc),
        .cur_exe_fun  (cur_exe_fun),
        .cur_op1_data (cur_op1_data),
        .cur_op2_data (cur_op2_data),
        .cur_rs2_data (cur_rs2_data),
        .cur_mem_wen  (cur_mem_wen),
        .cur_rf_wen   (cur_rf_wen),
        .cur_wb_sel   (cur_wb_sel),
        .cur_wb_addr  (cur_wb_addr),
        .cur_csr_cmd  (cur_csr_cmd),
        .cur_jmp_flg  (cur_jmp_flg),
        .cur_imm_i    (cur_imm_i),
        .cur_imm_b    (cur_imm_b)
    );

    alu #(
        .has_mul (has_mul)
    ) u_alu (
        .fun    (cur_exe_fun),
        .op1    (cur_op1_data),
        .op2    (cur_op2_data),
        .result (alu_result)
    );

    branch_unit u_branch (
        .fun    (cur_exe_fun),
        .op1    (cur_op1_data),
        .op2    (cur_op2_data),
        .pc     (cur_reg_pc),
        .imm_b  (cur_imm_b),
        .take   (br_take),
        .target (br_addr)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // EX/MEM pipeline register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // a taken branch in writeback kills whatever is in flight here
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n || wb_branch_hazard) begin
            alu_out      <= WORD_POISON;
            br_flg       <= 1'b0;
            br_target    <= WORD_POISON;
            out_reg_pc   <= REGPC_NOP;
            out_mem_wen  <= MEN_X;
            out_rf_wen   <= REN_X;
            out_rs2_data <= WORD_POISON;
            out_op1_data <= WORD_POISON;
            out_wb_sel   <= WB_X;
            out_wb_addr  <= '0;
            out_csr_cmd  <= CSR_X;
            out_jmp_flg  <= 1'b0;
            out_imm_i    <= WORD_POISON;
        end else begin
            alu_out      <= alu_result;
            br_flg       <= br_take;
            br_target    <= br_addr;
            out_reg_pc   <= cur_reg_pc;
            out_mem_wen  <= cur_mem_wen;
            out_rf_wen   <= cur_rf_wen;
            out_rs2_data <= cur_rs2_data;
            out_op1_data <= cur_op1_data;
            out_wb_sel   <= cur_wb_sel;
            out_wb_addr  <= cur_wb_addr;
            out_csr_cmd  <= cur_csr_cmd;
            out_jmp_flg  <= cur_jmp_flg;
            out_imm_i    <= cur_imm_i;
        end
    end

    // a flushed slot must never redirect fetch a second time
    a_no_branch_after_flush: assert property (
        @(posedge clk) disable iff (!arst_n)
        wb_branch_hazard |=> !br_flg
    );

    a_fun_known: assert property (
        @(posedge clk) disable iff (!arst_n)
        !$isunknown(cur_exe_fun)
    );

endmodule

// ==== test/tb_execute.sv ====
module tb_execute;

    import exec_pkg::*;

    localparam int MAX_CYCLES = 3000;

    typedef struct packed {
        word_t     reg_pc;
        exe_fun_t  exe_fun;
        word_t     op1;
        word_t     op2;
        word_t     rs2;
        mem_wen_t  mem_wen;
        logic      rf_wen;
        wb_sel_t   wb_sel;
        reg_addr_t wb_addr;
        csr_cmd_t  csr_cmd;
        logic      jmp_flg;
        word_t     imm_i;
        word_t     imm_b;
    } instr_t;

    typedef struct packed {
        word_t     alu_out;
        logic      br_flg;
        word_t     br_target;
        word_t     reg_pc;
        mem_wen_t  mem_wen;
        logic      rf_wen;
        word_t     rs2;
        word_t     op1;
        wb_sel_t   wb_sel;
        reg_addr_t wb_addr;
        csr_cmd_t  csr_cmd;
        logic      jmp_flg;
        word_t     imm_i;
    } expect_t;

    logic      clk;
    logic      arst_n;
    logic      stall_flg;
    logic      wb_branch_hazard;
    word_t     in_reg_pc;
    exe_fun_t  in_exe_fun;
    word_t     in_op1_data;
    word_t     in_op2_data;
    word_t     in_rs2_data;
    mem_wen_t  in_mem_wen;
    logic      in_rf_wen;
    wb_sel_t   in_wb_sel;
    reg_addr_t in_wb_addr;
    csr_cmd_t  in_csr_cmd;
    logic      in_jmp_flg;
    word_t     in_imm_i;
    word_t     in_imm_b;
    word_t     alu_out;
    logic      br_flg;
    word_t     br_target;
    word_t     out_reg_pc;
    mem_wen_t  out_mem_wen;
    logic      out_rf_wen;
    word_t     out_rs2_data;
    word_t     out_op1_data;
    wb_sel_t   out_wb_sel;
    reg_addr_t out_wb_addr;
    csr_cmd_t  out_csr_cmd;
    logic      out_jmp_flg;
    word_t     out_imm_i;

    instr_t  held;
    instr_t  idle_instr;
    expect_t want_now;
    expect_t want_next;
    int      err_count;
    int      err_mark;
    int      check_count;
    int      tests_ok;
    int      tests_bad;
    int      cycles;

    exe_fun_t base_funs[13] = '{ALU_X, ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL,
                                ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU, ALU_JALR, ALU_COPY1};
    exe_fun_t mul_funs[4]   = '{ALU_MUL, ALU_MULH, ALU_MULHSU, ALU_MULHU};
    exe_fun_t br_funs[6]    = '{BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU};

    execute_stage #(.has_mul(1'b1)) uut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic less_signed(input word_t a, input word_t b);
        return (a[31] != b[31]) ? a[31] : (a < b);
    endfunction

    function automatic word_t ref_alu(input exe_fun_t fun, input word_t a, input word_t b);
        logic [63:0] a_s;
        logic [63:0] b_s;
        logic [63:0] b_u;
        logic [63:0] p;
        word_t       r;
        a_s = {{32{a[31]}}, a};
        b_s = {{32{b[31]}}, b};
        b_u = {32'b0, b};
        p = '0;
        r = '0;
        case (fun)
            ALU_ADD:   r = a + b;
            ALU_SUB:   r = a - b;
            ALU_AND:   r = a & b;
            ALU_OR:    r = a | b;
            ALU_XOR:   r = a ^ b;
            ALU_SLL:   r = a << b[4:0];
            ALU_SRL:   r = a >> b[4:0];
            ALU_SLT:   r = {31'b0, less_signed(a, b)};
            ALU_SLTU:  r = {31'b0, a < b};
            ALU_COPY1: r = a;
            ALU_JALR: begin
                r = a + b;
                r[0] = 1'b0;
            end
            // sign extended copy shifted right gives the arithmetic shift
            ALU_SRA: begin
                p = a_s >> b[4:0];
                r = p[31:0];
            end
            ALU_MUL: begin
                p = a_s * b_s;
                r = p[31:0];
            end
            ALU_MULH: begin
                p = a_s * b_s;
                r = p[63:32];
            end
            ALU_MULHSU: begin
                p = a_s * b_u;
                r = p[63:32];
            end
            ALU_MULHU: begin
                p = {32'b0, a} * b_u;
                r = p[63:32];
            end
            default:   r = '0;
        endcase
        return r;
    endfunction

    function automatic logic ref_branch(input exe_fun_t fun, input word_t a, input word_t b);
        case (fun)
            BR_BEQ:  return a == b;
            BR_BNE:  return a != b;
            BR_BLT:  return less_signed(a, b);
            BR_BGE:  return !less_signed(a, b);
            BR_BLTU: return a < b;
            BR_BGEU: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    function automatic expect_t ref_execute(input instr_t s, input logic flush);
        expect_t r;
        if (flush) begin
            r = '{alu_out: WORD_POISON, br_flg: 1'b0, br_target: WORD_POISON,
                  reg_pc: REGPC_NOP, mem_wen: MEN_X, rf_wen: REN_X, rs2: WORD_POISON,
                  op1: WORD_POISON, wb_sel: WB_X, wb_addr: '0, csr_cmd: CSR_X,
                  jmp_flg: 1'b0, imm_i: WORD_POISON};
        end else begin
            r = '{alu_out: ref_alu(s.exe_fun, s.op1, s.op2),
                  br_flg: ref_branch(s.exe_fun, s.op1, s.op2),
                  br_target: s.reg_pc + s.imm_b, reg_pc: s.reg_pc, mem_wen: s.mem_wen,
                  rf_wen: s.rf_wen, rs2: s.rs2, op1: s.op1, wb_sel: s.wb_sel,
                  wb_addr: s.wb_addr, csr_cmd: s.csr_cmd, jmp_flg: s.jmp_flg,
                  imm_i: s.imm_i};
        end
        return r;
    endfunction

    // what a flush leaves in the held copy
    function automatic instr_t hold_bubble();
        return '{reg_pc: WORD_POISON, exe_fun: ALU_X, op1: WORD_POISON, op2: WORD_POISON,
                 rs2: WORD_POISON, mem_wen: MEN_X, rf_wen: REN_X, wb_sel: WB_X,
                 wb_addr: '0, csr_cmd: CSR_X, jmp_flg: 1'b0, imm_i: WORD_POISON,
                 imm_b: WORD_POISON};
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checking
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic report_fail(input string field, input logic [31:0] got,
                               input logic [31:0] want);
        err_count++;
        $display("Fail at time %0t: %s is %h, expected %h", $time, field, got, want);
    endtask

    task automatic check_word(input string field, input word_t got, input word_t want);
        check_count++;
        if (got !== want) report_fail(field, got, want);
    endtask

    task automatic check_flag(input string field, input logic got, input logic want);
        check_count++;
        if (got !== want) report_fail(field, {31'b0, got}, {31'b0, want});
    endtask

    task automatic check_mem_wen(input string field, input mem_wen_t got, input mem_wen_t want);
        check_count++;
        if (got !== want) report_fail(field, {28'b0, got}, {28'b0, want});
    endtask

    task automatic check_wb_sel(input string field, input wb_sel_t got, input wb_sel_t want);
        check_count++;
        if (got !== want) report_fail(field, {28'b0, got}, {28'b0, want});
    endtask

    task automatic check_addr(input string field, input reg_addr_t got, input reg_addr_t want);
        check_count++;
        if (got !== want) report_fail(field, {27'b0, got}, {27'b0, want});
    endtask

    task automatic check_csr(input string field, input csr_cmd_t got, input csr_cmd_t want);
        check_count++;
        if (got !== want) report_fail(field, {29'b0, got}, {29'b0, want});
    endtask

    // outputs are settled mid cycle, well clear of the driving edge
    initial begin
        @(posedge clk);
        forever begin
            @(negedge clk);
            check_word("alu_out", alu_out, want_now.alu_out);
            check_flag("br_flg", br_flg, want_now.br_flg);
            check_word("br_target", br_target, want_now.br_target);
            check_word("out_reg_pc", out_reg_pc, want_now.reg_pc);
            check_mem_wen("out_mem_wen", out_mem_wen, want_now.mem_wen);
            check_flag("out_rf_wen", out_rf_wen, want_now.rf_wen);
            check_word("out_rs2_data", out_rs2_data, want_now.rs2);
            check_word("out_op1_data", out_op1_data, want_now.op1);
            check_wb_sel("out_wb_sel", out_wb_sel, want_now.wb_sel);
            check_addr("out_wb_addr", out_wb_addr, want_now.wb_addr);
            check_csr("out_csr_cmd", out_csr_cmd, want_now.csr_cmd);
            check_flag("out_jmp_flg", out_jmp_flg, want_now.jmp_flg);
            check_word("out_imm_i", out_imm_i, want_now.imm_i);
        end
    end

    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("run timed out after %0d cycles before all tests finished", cycles);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic word_t pick_operand();
        case ($urandom_range(0, 7))
            0:       return 32'h0000_0000;
            1:       return 32'h8000_0000;
            2:       return 32'h7fff_ffff;
            3:       return 32'hffff_ffff;
            4:       return 32'h0000_0001;
            5:       return word_t'($urandom_range(31, 63));
            default: return $urandom;
        endcase
    endfunction

    function automatic instr_t rand_instr(input exe_fun_t fun);
        instr_t s;
        s.reg_pc  = $urandom;
        s.exe_fun = fun;
        s.op1     = pick_operand();
        s.op2     = pick_operand();
        s.rs2     = $urandom;
        s.mem_wen = mem_wen_t'($urandom);
        s.rf_wen  = 1'($urandom);
        s.wb_sel  = wb_sel_t'($urandom);
        s.wb_addr = reg_addr_t'($urandom);
        s.csr_cmd = csr_cmd_t'($urandom);
        s.jmp_flg = 1'($urandom);
        s.imm_i   = $urandom;
        s.imm_b   = $urandom;
        return s;
    endfunction

    function automatic exe_fun_t any_fun();
        int k;
        k = $urandom_range(0, 22);
        if (k < 13) return base_funs[k];
        if (k < 17) return mul_funs[k - 13];
        return br_funs[k - 17];
    endfunction

    // drives one cycle and predicts the outputs of the next edge
    task automatic apply(input instr_t s, input logic stall, input logic flush);
        instr_t sel;
        sel = stall ? held : s;
        want_now = want_next;
        in_reg_pc = s.reg_pc;
        in_exe_fun = s.exe_fun;
        in_op1_data = s.op1;
        in_op2_data = s.op2;
        in_rs2_data = s.rs2;
        in_mem_wen = s.mem_wen;
        in_rf_wen = s.rf_wen;
        in_wb_sel = s.wb_sel;
        in_wb_addr = s.wb_addr;
        in_csr_cmd = s.csr_cmd;
        in_jmp_flg = s.jmp_flg;
        in_imm_i = s.imm_i;
        in_imm_b = s.imm_b;
        stall_flg = stall;
        wb_branch_hazard = flush;
        want_next = ref_execute(sel, flush);
        held = flush ? hold_bubble() : sel;
    endtask

    task automatic step(input instr_t s, input logic stall, input logic flush);
        @(posedge clk);
        #1;
        apply(s, stall, flush);
    endtask

    task automatic end_test(input string name);
        repeat (2) step(idle_instr, 1'b0, 1'b0);
        if (err_count == err_mark) begin
            tests_ok++;
            $display("test %s finished without errors", name);
        end else begin
            tests_bad++;
            $display("test %s finished with %0d errors", name, err_count - err_mark);
        end
        err_mark = err_count;
    endtask

    initial begin
        instr_t s;
        int     n;
        void'($urandom(32'h0b0b_76d9));
        err_count = 0;
        err_mark = 0;
        check_count = 0;
        tests_ok = 0;
        tests_bad = 0;
        idle_instr = '0;
        held = hold_bubble();
        want_next = ref_execute(idle_instr, 1'b1);
        want_now = want_next;
        arst_n = 1'b0;
        apply(idle_instr, 1'b0, 1'b0);
        want_next = want_now;
        held = hold_bubble();

        // the checker sees the bubble on every cycle of reset
        repeat (16) @(posedge clk);
        #1;
        arst_n = 1'b1;
        apply(idle_instr, 1'b0, 1'b0);
        end_test("reset");

        for (int i = 0; i < 400; i++) begin
            step(rand_instr(base_funs[$urandom_range(0, 12)]), 1'b0, 1'b0);
        end
        end_test("base_alu");

        for (int i = 0; i < 200; i++) begin
            step(rand_instr(mul_funs[$urandom_range(0, 3)]), 1'b0, 1'b0);
        end
        end_test("multiply");

        for (int i = 0; i < 200; i++) begin
            s = rand_instr(($urandom_range(0, 7) == 0) ? any_fun()
                                                       : br_funs[$urandom_range(0, 5)]);
            case ($urandom_range(0, 4))
                0: s.op2 = s.op1;
                1: s.op2 = s.op1 + 32'd1;
                2: s.op2 = s.op1 - 32'd1;
                3: s.op2 = s.op1 ^ 32'h8000_0000;
                default: s.op2 = pick_operand();
            endcase
            step(s, 1'b0, 1'b0);
        end
        end_test("branch");

        for (int i = 0; i < 200; i++) begin
            step(rand_instr(any_fun()), 1'b0, 1'b0);
        end
        end_test("pass_through");

        for (int i = 0; i < 150; i++) begin
            step(rand_instr(any_fun()), 1'b0, 1'b0);
            n = $urandom_range(1, 4);
            repeat (n) step(rand_instr(any_fun()), 1'b1, 1'b0);
        end
        end_test("stall");

        // flush alone, flush with stall, then a stall that replays the bubble
        for (int i = 0; i < 60; i++) begin
            step(rand_instr(any_fun()), 1'b0, 1'b0);
            step(rand_instr(br_funs[$urandom_range(0, 5)]), 1'b0, 1'b1);
            step(rand_instr(any_fun()), 1'b1, 1'b1);
            step(rand_instr(any_fun()), 1'b1, 1'b0);
            step(rand_instr(any_fun()), 1'b0, 1'b0);
        end
        end_test("flush");

        $display("tests passed %0d, tests failed %0d, checks %0d, errors %0d",
                 tests_ok, tests_bad, check_count, err_count);
        if (tests_bad == 0 && err_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
common/exec_pkg.sv
execute/alu.sv
execute/branch_unit.sv
execute/operand_hold.sv
execute/execute_stage.sv
test/tb_execute.sv

// ==== Makefile ====
TOP := tb_execute

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module execute_stage \
		common/exec_pkg.sv execute/alu.sv execute/branch_unit.sv \
		execute/operand_hold.sv execute/execute_stage.sv
	verilator --lint-only --timing --top-module $(TOP) -f compile.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f compile.f -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
